// File: ldpc_syndrome_check_top.f
+incdir+design
design/ldpc_dec_pkg.sv
design/ldpc_hd_ram.sv
design/ldpc_syn_ctrl.sv
design/ldpc_cyclic_shift.sv
design/ldpc_syndrome_count.sv
design/ldpc_syndrome_check_top.sv
test/tb_clk_gen.sv
test/ldpc_syndrome_check_chk.sv
test/tb_ldpc_syndrome_check.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_ldpc_syndrome_check \
		-f ldpc_syndrome_check_top.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_ldpc_syndrome_check.sv
// directed testbench for the ldpc syndrome check stage with a table driven reference model
`timescale 1ns/1ps
`default_nettype none

module tb_ldpc_syndrome_check;

  localparam int Z      = 16;
  localparam int COLS   = ldpc_dec_pkg::COLS;
  localparam int FRAMES = 23; // frames sent over all tests
  localparam int HOLD   = 10; // back-pressure cycles in the hold test
  localparam int LIMIT  = FRAMES * (COLS + ldpc_dec_pkg::EDGES + 5 + HOLD) * 2;

  `include "ldpc_base_matrix.svh"

  logic         iclk;
  logic         ireset;
  logic         in_valid;
  logic         in_ready;
  logic [Z-1:0] in_data;
  logic         out_valid;
  logic         out_ready;
  logic         out_fail;

  logic [Z-1:0] frame [COLS]; // codeword under test
  logic [31:0]  lcg_state;
  int           errors;
  int           tests;
  int           cycles = 0;

  tb_clk_gen u_clk_gen (
    .iclk   (iclk),
    .ireset (ireset)
  );

  ldpc_syndrome_check_top #(.Z(Z)) u_ldpc_syndrome_check_top (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_fail  (out_fail)
  );

  bind ldpc_syndrome_check_top ldpc_syndrome_check_chk #(.Z(Z)) u_chk (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_fail  (out_fail)
  );

  // watchdog sized from the frame count
  always @(posedge iclk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, the DUT never finished the tests", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // lcg step with the upper bits as the word
  function automatic logic [Z-1:0] rand_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // out bit i takes in bit (i + s) mod Z
  function automatic logic [Z-1:0] rotate(input logic [Z-1:0] w, input int s);
    logic [Z-1:0] r;
    for (int i = 0; i < Z; i++) begin
      r[i] = w[(i + s) % Z];
    end
    return r;
  endfunction

  // reference flag set by any row whose rotated words xor to non-zero
  function automatic logic expected_fail();
    logic [Z-1:0] syn;
    logic         fail;
    int           e;
    fail = 1'b0;
    for (int r = 0; r < ldpc_dec_pkg::ROWS; r++) begin
      syn = '0;
      for (int k = 0; k < ldpc_dec_pkg::ROW_W; k++) begin
        e   = r * ldpc_dec_pkg::ROW_W + k; // table is in row order
        syn = syn ^ rotate(frame[edge_col[e]], int'(edge_shift[e]));
      end
      fail = fail | (|syn);
    end
    return fail;
  endfunction

  task automatic fill_frame(input logic [Z-1:0] w);
    for (int c = 0; c < COLS; c++) begin
      frame[c] = w;
    end
  endtask

  // words offered on the falling edge and taken on the next rising edge when in_ready
  task automatic send_frame();
    int c;
    c = 0;
    while (c < COLS) begin
      @(negedge iclk);
      in_valid = 1'b1;
      in_data  = frame[c];
      if (in_ready) begin
        c++;
      end
    end
    @(negedge iclk);
    in_valid = 1'b0;
  endtask

  task automatic wait_result();
    while (!out_valid) begin
      @(negedge iclk); // one poll per cycle until the result shows
    end
  endtask

  task automatic take_result(input logic want);
    wait_result();
    if (out_fail !== want) begin
      $display("FAIL out_fail got %h expected %h", out_fail, want);
      errors++;
    end
    out_ready = 1'b1;
    @(negedge iclk);
    out_ready = 1'b0;
    if (out_valid !== 1'b0) begin
      $display("FAIL out_valid got %h expected 0", out_valid);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s had %0d errors", name, errors - err_before);
    end
  endtask

  task automatic test_all_zero();
    int e0;
    e0 = errors;
    if (out_valid !== 1'b0) begin
      $display("FAIL out_valid got %h expected 0", out_valid);
      errors++;
    end
    if (in_ready !== 1'b1) begin
      $display("FAIL in_ready got %h expected 1", in_ready);
      errors++;
    end
    fill_frame('0);
    send_frame();
    take_result(1'b0);
    end_test("all_zero", e0);
  endtask

  task automatic test_all_ones();
    int e0;
    e0 = errors;
    fill_frame('1); // even row weight keeps every check satisfied
    send_frame();
    take_result(1'b0);
    end_test("all_ones", e0);
  endtask

  task automatic test_single_bit();
    int e0;
    e0 = errors;
    for (int c = 0; c < COLS; c++) begin
      fill_frame('0);
      frame[c][int'(rand_word()) % Z] = 1'b1; // one error per column tried
      send_frame();
      take_result(1'b1);
    end
    end_test("single_bit", e0);
  endtask

  task automatic test_random();
    int   e0;
    logic want;
    e0 = errors;
    for (int n = 0; n < 10; n++) begin
      for (int c = 0; c < COLS; c++) begin
        frame[c] = rand_word();
      end
      want = expected_fail();
      send_frame();
      take_result(want);
    end
    end_test("random", e0);
  endtask

  task automatic test_hold();
    int   e0;
    logic want;
    e0 = errors;
    for (int c = 0; c < COLS; c++) begin
      frame[c] = rand_word();
    end
    want = expected_fail();
    send_frame();
    wait_result();
    repeat (HOLD) begin
      @(negedge iclk); // out_ready stays low
      if (out_valid !== 1'b1) begin
        $display("FAIL out_valid got %h expected 1", out_valid);
        errors++;
      end
      if (out_fail !== want) begin
        $display("FAIL out_fail got %h expected %h", out_fail, want);
        errors++;
      end
      if (in_ready !== 1'b0) begin
        $display("FAIL in_ready got %h expected 0", in_ready);
        errors++;
      end
    end
    take_result(want);
    end_test("hold", e0);
  endtask

  task automatic test_back_to_back();
    int e0;
    e0 = errors;
    fill_frame('0);
    frame[3][5] = 1'b1;
    send_frame();
    take_result(1'b1);
    fill_frame('0); // flag must clear at the new frame
    send_frame();
    take_result(1'b0);
    end_test("back_to_back", e0);
  endtask

  initial begin
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    lcg_state = 32'd95;
    errors    = 0;
    tests     = 0;
    @(negedge iclk);
    while (ireset) begin
      @(negedge iclk);
    end
    test_all_zero();
    test_all_ones();
    test_single_bit();
    test_random();
    test_hold();
    test_back_to_back();
    $display("tests %0d errors %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/ldpc_syndrome_check_chk.sv
// handshake assertions bound onto the syndrome check top level from the testbench
`timescale 1ns/1ps
`default_nettype none

module ldpc_syndrome_check_chk #(
  parameter int Z = 16 // word width in bits
) (
  input wire         iclk,
  input wire         ireset,
  input wire         in_valid,
  input wire [Z-1:0] in_data,
  input wire         out_valid,
  input wire         out_ready,
  input wire         out_fail
);

  // an offered word carries no x or z
  a_in_known: assert property (@(posedge iclk) disable iff (ireset)
    in_valid |-> !$isunknown(in_data))
    else $error("in_data unknown while in_valid is high");

  // result and its flag hold until the sink takes them
  a_out_hold: assert property (@(posedge iclk) disable iff (ireset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_fail)))
    else $error("result dropped or changed before out_ready");

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// clock and reset source for the syndrome check testbench with a 20 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic iclk,
  output logic ireset
);

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk; // 20 ns period
  end

  // reset held for four rising edges, dropped away from the active edge
  initial begin
    ireset = 1'b1;
    repeat (4) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
  end

endmodule

`default_nettype wire

// File: design/ldpc_syndrome_check_top.sv
// parity check stage top level joining controller memory shifter and syndrome counter
`timescale 1ns/1ps
`default_nettype none

module ldpc_syndrome_check_top #(
  parameter int Z = 16 // word width in bits and at least 8
) (
  input  wire         iclk,
  input  wire         ireset,
  // codeword input in column order
  input  wire         in_valid,
  output logic        in_ready,
  input  wire [Z-1:0] in_data,
  // pass or fail result
  output logic        out_valid,
  input  wire         out_ready,
  output logic        out_fail
);

  // memory write
  logic                           wr_en;
  logic [ldpc_dec_pkg::COL_W-1:0] wr_addr;

  // edge issue
  logic                           rd_en;
  logic [ldpc_dec_pkg::COL_W-1:0] rd_addr;
  logic [ldpc_dec_pkg::SHF_W-1:0] edge_shift;
  logic                           sop;
  logic                           eop;
  logic                           sof;
  logic [Z-1:0]                   rd_data;

  // shifter to counter
  logic                           sh_val;
  logic                           sh_sop;
  logic                           sh_eop;
  logic                           sh_sof;
  logic [Z-1:0]                   sh_data;

  // counter back to controller
  logic                           row_val;
  logic                           frame_fail;

  ldpc_syn_ctrl u_ctrl (
    .iclk       (iclk),
    .ireset     (ireset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .edge_shift (edge_shift),
    .sop        (sop),
    .eop        (eop),
    .sof        (sof),
    .row_val    (row_val),
    .frame_fail (frame_fail),
    .out_valid  (out_valid),
    .out_fail   (out_fail),
    .out_ready  (out_ready)
  );

  ldpc_hd_ram #(.Z(Z)) u_hd_ram (
    .iclk    (iclk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (in_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // issue goes straight in and is delayed inside to meet rd_data
  ldpc_cyclic_shift #(.Z(Z)) u_shift (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (rd_en),
    .shift  (edge_shift),
    .sop    (sop),
    .eop    (eop),
    .sof    (sof),
    .data   (rd_data),
    .oval   (sh_val),
    .osop   (sh_sop),
    .oeop   (sh_eop),
    .osof   (sh_sof),
    .odata  (sh_data)
  );

  ldpc_syndrome_count #(.Z(Z)) u_syn_count (
    .iclk     (iclk),
    .ireset   (ireset),
    .ival     (sh_val),
    .sop      (sh_sop),
    .eop      (sh_eop),
    .sof      (sh_sof),
    .vnode_hd (sh_data),
    .oval     (row_val),
    .odat     (frame_fail)
  );

endmodule

`default_nettype wire

// File: design/ldpc_syndrome_count.sv
// row syndrome XOR and frame wide non-zero flag fed by rotated hard decision words
`timescale 1ns/1ps
`default_nettype none

module ldpc_syndrome_count #(
  parameter int Z = 16 // word width in bits
) (
  input  wire         iclk,
  input  wire         ireset,
  // one rotated word per edge
  input  wire         ival,
  input  wire         sop,      // first edge of a row
  input  wire         eop,      // last edge of a row
  input  wire         sof,      // first edge of the frame
  input  wire [Z-1:0] vnode_hd,
  // row done pulse and running frame flag
  output logic        oval,
  output logic        odat
);

  logic         syn_val;  // row syndrome complete
  logic [Z-1:0] syndrome; // XOR of the rotated words of the current row

  // control pipe
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syn_val <= 1'b0;
      oval    <= 1'b0;
    end else begin
      syn_val <= ival & eop;
      oval    <= syn_val; // odat already holds this row
    end
  end

  always_ff @(posedge iclk) begin
    // row syndrome restarts on sop
    if (ival) begin
      syndrome <= sop ? vnode_hd : (syndrome ^ vnode_hd);
    end
    // frame flag
    if (ival & sop & sof) begin
      odat <= 1'b0;                  // new frame
    end else if (syn_val) begin
      odat <= odat | (|syndrome);    // any unsatisfied check fails the frame
    end
  end

endmodule

`default_nettype wire

// File: design/ldpc_cyclic_shift.sv
// registered cyclic rotation of a read word by its edge shift with strobes kept aligned
`timescale 1ns/1ps
`default_nettype none

module ldpc_cyclic_shift #(
  parameter int Z = 16 // word width in bits
) (
  input  wire                           iclk,
  input  wire                           ireset,
  // edge issue straight from the controller
  input  wire                           ival,
  input  wire [ldpc_dec_pkg::SHF_W-1:0] shift,
  input  wire                           sop,
  input  wire                           eop,
  input  wire                           sof,
  // word from the memory one cycle later
  input  wire [Z-1:0]                   data,
  // rotated word toward the syndrome counter
  output logic                          oval,
  output logic                          osop,
  output logic                          oeop,
  output logic                          osof,
  output logic [Z-1:0]                  odata
);

  logic                           val_q;   // issue delayed by the memory latency
  logic                           sop_q;
  logic                           eop_q;
  logic                           sof_q;
  logic [ldpc_dec_pkg::SHF_W-1:0] shift_q;
  logic [2*Z-1:0]                 dbl;     // doubled word so a right shift rotates

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_q <= 1'b0;
      sop_q <= 1'b0;
      eop_q <= 1'b0;
      sof_q <= 1'b0;
      oval  <= 1'b0;
      osop  <= 1'b0;
      oeop  <= 1'b0;
      osof  <= 1'b0;
    end else begin
      val_q <= ival;        // lines up with rd_data
      sop_q <= ival & sop;
      eop_q <= ival & eop;
      sof_q <= ival & sof;
      oval  <= val_q;       // lines up with odata
      osop  <= sop_q;
      oeop  <= eop_q;
      osof  <= sof_q;
    end
  end

  // out bit i takes in bit (i + shift) mod Z
  assign dbl = {data, data} >> shift_q;

  always_ff @(posedge iclk) begin
    shift_q <= shift;
    if (val_q) begin
      odata <= dbl[Z-1:0];
    end
  end

endmodule

`default_nettype wire

// File: design/ldpc_syn_ctrl.sv
// frame controller that loads a codeword and walks the edge table then returns the result
`timescale 1ns/1ps
`default_nettype none

module ldpc_syn_ctrl (
  input  wire                           iclk,
  input  wire                           ireset,
  // codeword input
  input  wire                           in_valid,
  output logic                          in_ready,
  output logic                          wr_en,
  output logic [ldpc_dec_pkg::COL_W-1:0] wr_addr,
  // edge issue toward memory and shifter
  output logic                          rd_en,
  output logic [ldpc_dec_pkg::COL_W-1:0] rd_addr,
  output logic [ldpc_dec_pkg::SHF_W-1:0] edge_shift,
  output logic                          sop,
  output logic                          eop,
  output logic                          sof,
  // row results from the syndrome counter
  input  wire                           row_val,
  input  wire                           frame_fail,
  // result output
  output logic                          out_valid,
  output logic                          out_fail,
  input  wire                           out_ready
);

  localparam int POS_W = $clog2(ldpc_dec_pkg::ROW_W); // edge position inside a row

  ldpc_dec_pkg::ctrl_state_t state;

  logic [ldpc_dec_pkg::COL_W-1:0]     word_cnt;  // words loaded so far
  logic [ldpc_dec_pkg::EDGE_W-1:0]    edge_idx;  // edge being issued
  logic [ldpc_dec_pkg::ROW_CNT_W-1:0] row_cnt;   // row pulses seen this frame
  logic [POS_W-1:0]                   edge_pos;
  logic [ldpc_dec_pkg::SHF_W-1:0]     tab_shift; // shift looked up for edge_idx
  logic                               run;
  logic                               last_word;
  logic                               last_edge;
  logic                               cnt_en;
  logic                               last_row;
  logic                               take;

  // edge tables in a local scope where edge_shift names the table
  if (1) begin : g_tab
    `include "ldpc_base_matrix.svh"
    assign rd_addr   = edge_col[edge_idx];
    assign tab_shift = edge_shift[edge_idx];
  end

  assign edge_shift = tab_shift;

  // input side
  assign in_ready  = (state == ldpc_dec_pkg::LOAD); // accept only while loading
  assign wr_en     = in_valid & in_ready;
  assign wr_addr   = word_cnt;
  assign last_word = wr_en && (word_cnt == ldpc_dec_pkg::COL_W'(ldpc_dec_pkg::COLS - 1));

  // edge issue
  assign run       = (state == ldpc_dec_pkg::RUN);
  assign edge_pos  = edge_idx[POS_W-1:0];
  assign rd_en     = run;
  assign sop       = run && (edge_pos == '0);                                      // row start
  assign eop       = run && (edge_pos == POS_W'(ldpc_dec_pkg::ROW_W - 1));         // row end
  assign sof       = run && (edge_idx == '0);                                      // frame start
  assign last_edge = run && (edge_idx == ldpc_dec_pkg::EDGE_W'(ldpc_dec_pkg::EDGES - 1));

  // row result counting while edges are in flight
  assign cnt_en   = row_val && (run || (state == ldpc_dec_pkg::DRAIN));
  assign last_row = cnt_en && (row_cnt == ldpc_dec_pkg::ROW_CNT_W'(ldpc_dec_pkg::ROWS - 1));

  // output handshake
  assign out_valid = (state == ldpc_dec_pkg::DONE);
  assign take      = out_valid & out_ready;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= ldpc_dec_pkg::LOAD;
      word_cnt <= '0;
      edge_idx <= '0;
      row_cnt  <= '0;
      out_fail <= 1'b0;
    end else begin
      if (wr_en) begin
        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
      end
      if (run) begin
        edge_idx <= last_edge ? '0 : edge_idx + 1'b1; // one edge per cycle
      end
      if (cnt_en) begin
        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
      end
      if (last_row) begin
        out_fail <= frame_fail; // frame flag is final with the last row pulse
      end
      case (state)
        ldpc_dec_pkg::LOAD: begin
          if (last_word) begin
            state <= ldpc_dec_pkg::RUN;
          end
        end
        ldpc_dec_pkg::RUN: begin
          if (last_edge) begin
            state <= ldpc_dec_pkg::DRAIN;
          end
        end
        ldpc_dec_pkg::DRAIN: begin
          if (last_row) begin
            state <= ldpc_dec_pkg::DONE;
          end
        end
        ldpc_dec_pkg::DONE: begin
          if (take) begin
            state <= ldpc_dec_pkg::LOAD; // ready for the next codeword
          end
        end
        default: state <= ldpc_dec_pkg::LOAD;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/ldpc_hd_ram.sv
// hard decision word memory holding one codeword with a registered read port
`timescale 1ns/1ps
`default_nettype none

module ldpc_hd_ram #(
  parameter int Z = 16 // word width in bits
) (
  input  wire                           iclk,
  // write side fed from the input handshake
  input  wire                           wr_en,
  input  wire [ldpc_dec_pkg::COL_W-1:0] wr_addr,
  input  wire [Z-1:0]                   wr_data,
  // read side driven by the edge schedule
  input  wire                           rd_en,
  input  wire [ldpc_dec_pkg::COL_W-1:0] rd_addr,
  output logic [Z-1:0]                  rd_data
);

  // one word per base matrix column
  logic [Z-1:0] mem [ldpc_dec_pkg::COLS];

  // write port
  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data; // words land in column order
    end
  end

  // read port with one cycle latency
  // rd_data holds its value while rd_en is low
  always_ff @(posedge iclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: design/ldpc_dec_pkg.sv
// shared base matrix sizes and controller states for the ldpc syndrome check stage
`default_nettype none

package ldpc_dec_pkg;

  // base matrix geometry
  localparam int ROWS  = 4;            // check rows in the base matrix
  localparam int COLS  = 8;            // columns which is also words per codeword
  localparam int ROW_W = 4;            // edges per row
  localparam int EDGES = ROWS * ROW_W; // total edges walked per frame

  // index widths
  localparam int COL_W     = $clog2(COLS);  // word address into the hd memory
  localparam int SHF_W     = 3;             // all table shifts stay below 8
  localparam int EDGE_W    = $clog2(EDGES); // edge table index
  localparam int ROW_CNT_W = $clog2(ROWS) + 1;

  // frame controller states
  typedef enum logic [1:0] {
    LOAD,  // take codeword words from the input
    RUN,   // issue one edge per cycle
    DRAIN, // edges issued and row results still in flight
    DONE   // result held until out_ready
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/ldpc_base_matrix.svh
// base matrix edge tables in row order for `include inside a module or generate scope

// column (codeword word) read by each edge
localparam logic [ldpc_dec_pkg::COL_W-1:0] edge_col [ldpc_dec_pkg::EDGES] = '{
  3'd0, // row 0
  3'd1,
  3'd2,
  3'd3,
  3'd4, // row 1
  3'd5,
  3'd6,
  3'd7,
  3'd0, // row 2 uses the even columns
  3'd2,
  3'd4,
  3'd6,
  3'd1, // row 3 uses the odd columns
  3'd3,
  3'd5,
  3'd7
};

// cyclic shift applied to the word of each edge
localparam logic [ldpc_dec_pkg::SHF_W-1:0] edge_shift [ldpc_dec_pkg::EDGES] = '{
  3'd0, // row 0
  3'd3,
  3'd5,
  3'd7,
  3'd1, // row 1
  3'd2,
  3'd4,
  3'd6,
  3'd2, // row 2
  3'd7,
  3'd0,
  3'd5,
  3'd6, // row 3
  3'd1,
  3'd3,
  3'd4
};
